// File: dv/rvCoreTb.sv
`include "rv_defines.svh"

module rvCoreTb import rvPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumRet     = 200;
  localparam int ProgLen    = 48;                // jal-to-self sits at this index
  localparam int CycleLimit = NumRet * 6 + 20;

  logic                clk;
  logic                rst;
  logic [`XLEN-1:0]    imemAdr;
  logic [`INSTR_W-1:0] imemData;
  dmemReqT             dmemReq;
  logic                dmemReady;
  logic [`XLEN-1:0]    dmemRdata;
  retireT              retire;

  logic [31:0] imem [256];
  logic [31:0] dmem [64];
  logic [31:0] refMem [64];    // model's view of data memory
  logic [31:0] lfsrState = 32'h25ad_049d;
  logic        randomReady;
  logic        running;
  logic        timedOut;
  int          retCount;
  int          testErrors;
  int          passCount;
  int          failCount;
  logic [31:0] expPc [NumRet];
  logic [4:0]  expRd [NumRet];
  logic        expWr [NumRet];
  logic [31:0] expData [NumRet];

  assign imemData  = imem[imemAdr[9:2]];
  assign dmemRdata = dmem[dmemReq.adr[7:2]];   // load data in the accept cycle

  rvCore rvCore_inst (.clk, .rst, .imemAdr, .imemData, .dmemReq, .dmemReady,
    .dmemRdata, .retire);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
  endtask

  function automatic logic [31:0] dataPattern(input int idx);
    return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // kind 0-4 is reg-reg, 5-7 reg-imm, 8 lui, 9-10 lw, 11-12 sw, 13-14 branch, 15 jal
  task automatic genProgram(input int kindBase, input int kindRange);
    logic [31:0] r;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          kind;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    for (int i = 1; i < 8; i++) begin   // prologue gives x1..x7 known values
      takeBits(12, r);
      imem[i-1] = encI(r[11:0], 5'd0, 3'b000, 5'(i), 7'b0010011);
    end
    for (int i = 7; i < ProgLen; i++) begin
      takeBits(13, r);
      rd   = {2'b00, r[2:0]};
      rs1  = {2'b00, r[5:3]};
      rs2  = {2'b00, r[8:6]};
      kind = kindBase + int'(r[12:9]) % kindRange;
      if (kind >= 13 && i > ProgLen - 3) begin
        kind = 5;   // no room for a forward jump
      end
      takeBits(20, imm);
      case (kind)
        0: imem[i] = encR(imm[0] ? 7'b0100000 : 7'b0000000, rs2, rs1, 3'b000, rd);
        1: imem[i] = encR(7'b0, rs2, rs1, 3'b010, rd);
        2: imem[i] = encR(7'b0, rs2, rs1, 3'b100, rd);
        3: imem[i] = encR(7'b0, rs2, rs1, 3'b110, rd);
        4: imem[i] = encR(7'b0, rs2, rs1, 3'b111, rd);
        5: imem[i] = encI(imm[11:0], rs1, 3'b000, rd, 7'b0010011);
        6: imem[i] = encI(imm[11:0], rs1, imm[12] ? 3'b110 : 3'b100, rd, 7'b0010011);
        7: imem[i] = encI(imm[11:0], rs1, 3'b111, rd, 7'b0010011);
        8: imem[i] = {imm[19:0], rd, 7'b0110111};
        9, 10: imem[i] = encI({4'b0000, imm[5:0], 2'b00}, 5'd0, 3'b010, rd, 7'b0000011);
        11, 12: imem[i] = encS({4'b0000, imm[5:0], 2'b00}, rs2, 5'd0);
        13, 14: imem[i] = encB(imm[0] ? 13'd12 : 13'd8, rs2, rs1, kind == 13 ? 3'b000 : 3'b001);
        default: imem[i] = encJ(21'd8, rd);
      endcase
    end
    imem[ProgLen] = encJ(21'd0, 5'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void buildExpected();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] adr;
    logic        wr;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    pc = `RESET_PC;
    for (int n = 0; n < NumRet; n++) begin
      w   = imem[pc[9:2]];
      a   = x[w[19:15]];
      b   = x[w[24:20]];
      wr  = 1'b0;
      val = '0;
      npc = pc + 32'd4;
      case (w[6:0])
        7'b0110011: begin
          wr  = 1'b1;
          val = aluRef(w[14:12], w[30], a, b);
        end
        7'b0010011: begin
          wr  = 1'b1;
          val = aluRef(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
        end
        7'b0110111: begin
          wr  = 1'b1;
          val = {w[31:12], 12'b0};
        end
        7'b0000011: begin
          wr  = 1'b1;
          adr = a + {{20{w[31]}}, w[31:20]};
          val = refMem[adr[7:2]];
        end
        7'b0100011: begin
          adr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          refMem[adr[7:2]] = b;
        end
        7'b1100011: begin
          if ((a == b) != w[12]) begin   // funct3 bit 0 selects bne
            npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        7'b1101111: begin
          wr  = 1'b1;
          val = pc + 32'd4;
          npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        default: wr = 1'b0;
      endcase
      if (w[11:7] == 5'd0) begin
        wr = 1'b0;
      end
      expPc[n]   = pc;
      expRd[n]   = w[11:7];
      expWr[n]   = wr;
      expData[n] = val;
      if (wr) begin
        x[w[11:7]] = val;
      end
      pc = npc;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // memory side and checking
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] bits;
    if (randomReady) begin
      takeBits(2, bits);
      dmemReady <= (bits[1:0] != 2'b00);   // ready about three cycles in four
    end else begin
      dmemReady <= 1'b1;
    end
    if (dmemReq.valid && dmemReady && dmemReq.write) begin
      dmem[dmemReq.adr[7:2]] <= dmemReq.wdata;
    end
  end

  task automatic reportError(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("Error: %0t %s expected %h actual %h", $time, name, expected, actual);
    testErrors++;
  endtask

  always @(posedge clk) begin
    if (running && !rst && retire.valid && retCount < NumRet) begin
      assert (retire.pc == expPc[retCount])
        else reportError("retire.pc", expPc[retCount], retire.pc);
      assert (retire.regWrite == expWr[retCount])
        else reportError("retire.regWrite", 32'(expWr[retCount]), 32'(retire.regWrite));
      if (expWr[retCount]) begin
        assert (retire.rd == expRd[retCount])
          else reportError("retire.rd", 32'(expRd[retCount]), 32'(retire.rd));
        assert (retire.data == expData[retCount])
          else reportError("retire.data", expData[retCount], retire.data);
      end
      retCount = retCount + 1;
    end
  end

  task automatic runTest(input int num, input string name, input int kindBase,
                         input int kindRange, input logic randReady);
    int cycles;
    if (timedOut) begin
      return;   // run already aborted
    end
    cycles     = 0;
    testErrors = 0;
    @(posedge clk);
    rst <= 1'b1;
    randomReady = 1'b0;
    @(posedge clk);
    genProgram(kindBase, kindRange);
    for (int i = 0; i < 64; i++) begin
      dmem[i]  <= dataPattern(i);
      refMem[i] = dataPattern(i);
    end
    buildExpected();
    retCount = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);   // first cycle out of reset
    running     = 1'b1;
    randomReady = randReady;
    assert (imemAdr == `RESET_PC) else reportError("imemAdr", `RESET_PC, imemAdr);
    assert (!retire.valid) else reportError("retire.valid", 32'd0, 32'(retire.valid));
    assert (!dmemReq.valid) else reportError("dmemReq.valid", 32'd0, 32'(dmemReq.valid));
    while (retCount < NumRet && cycles < CycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    running     = 1'b0;
    randomReady = 1'b0;
    if (retCount < NumRet) begin
      $display("test %0d (%s) timed out after %0d cycles, %0d of %0d retirements seen",
               num, name, cycles, retCount, NumRet);
      failCount++;
      timedOut = 1'b1;
    end else begin
      for (int i = 0; i < 64; i++) begin
        assert (dmem[i] == refMem[i]) else reportError("dmem", refMem[i], dmem[i]);
      end
      if (testErrors == 0) begin
        passCount++;
        $display("test %0d (%s): pass", num, name);
      end else begin
        failCount++;
        $display("test %0d (%s): fail, %0d errors", num, name, testErrors);
      end
    end
  endtask

  initial begin
    rst         <= 1'b1;
    dmemReady   <= 1'b0;
    randomReady = 1'b0;
    running     = 1'b0;
    timedOut    = 1'b0;
    retCount    = 0;
    passCount   = 0;
    failCount   = 0;
    runTest(0, "alu chains", 0, 9, 1'b0);
    runTest(1, "load use", 5, 6, 1'b0);
    runTest(2, "branches and jal", 0, 16, 1'b0);
    runTest(3, "stores and loads", 7, 6, 1'b0);
    runTest(4, "random ready", 0, 16, 1'b1);
    $display("passed %0d failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dv/rvCore_props.sv
module rvCoreProps import rvPkg::*; (
  input logic    clk,
  input logic    rst,
  input dmemReqT dmemReq,
  input logic    dmemReady,
  input retireT  retire
);

  timeunit 1ns;
  timeprecision 100ps;

  // a waiting request keeps address, data and direction
  reqStable: assert property (@(posedge clk) disable iff (rst)
    dmemReq.valid && !dmemReady |=> $stable(dmemReq))
    else $error("data request changed while waiting for ready");

  // nothing leaves the core right after a reset edge
  resetQuiet: assert property (@(posedge clk)
    rst |=> !dmemReq.valid && !retire.valid)
    else $error("request or retirement valid after reset");

  pcAligned: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.pc[1:0] == 2'b00)
    else $error("retired pc not word aligned");

endmodule

////////////////////////////////////////////////////////////
// attach to every core instance
////////////////////////////////////////////////////////////

bind rvCore rvCoreProps props (.*);

// File: hw/execUnit.sv
`include "rv_defines.svh"

module execUnit import rvPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                stallE,
  input  logic                flushE,
  input  logic [`INSTR_W-1:0] instrD,
  input  logic [`XLEN-1:0]    pcD,
  input  logic                validD,
  output hazardInfoT          hazardInfo,
  output redirectT            redirect,
  output exMemT               exMem,
  input  fwdT                 fwdM,
  input  retireT              retireW
);

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  opcodeE                 opD;
  logic [2:0]             funct3D;
  logic [6:0]             funct7D;
  logic [`REG_ADDR_W-1:0] rs1D;
  logic [`REG_ADDR_W-1:0] rs2D;
  logic [`REG_ADDR_W-1:0] rdD;
  ctrlT                   ctrlD;
  logic [`XLEN-1:0]       immD;
  logic                   legalD;

  assign opD     = opcodeE'(instrD[6:0]);
  assign funct3D = instrD[14:12];
  assign funct7D = instrD[31:25];
  assign rs1D    = instrD[19:15];
  assign rs2D    = instrD[24:20];
  assign rdD     = instrD[11:7];

  always_comb begin
    ctrlD       = '0;
    ctrlD.aluOp = ADD;
    immD        = '0;
    legalD      = 1'b0;
    case (opD)
      OP: begin
        ctrlD.regWrite = 1'b1;
        legalD = (funct7D == 7'b0000000) || (funct7D == 7'b0100000 && funct3D == 3'b000);
        case (funct3D)
          3'b000:  ctrlD.aluOp = funct7D[5] ? SUB : ADD;
          3'b010:  ctrlD.aluOp = SLT;
          3'b100:  ctrlD.aluOp = XOR;
          3'b110:  ctrlD.aluOp = OR;
          3'b111:  ctrlD.aluOp = AND;
          default: legalD = 1'b0;
        endcase
      end
      OP_IMM: begin
        immD           = {{20{instrD[31]}}, instrD[31:20]};
        ctrlD.regWrite = 1'b1;
        ctrlD.useImm   = 1'b1;
        legalD         = 1'b1;
        case (funct3D)
          3'b000:  ctrlD.aluOp = ADD;
          3'b100:  ctrlD.aluOp = XOR;
          3'b110:  ctrlD.aluOp = OR;
          3'b111:  ctrlD.aluOp = AND;
          default: legalD = 1'b0;   // slti and shifts not in the subset
        endcase
      end
      LUI: begin
        immD           = {instrD[31:12], 12'b0};
        ctrlD.regWrite = 1'b1;
        ctrlD.useImm   = 1'b1;
        ctrlD.aluOp    = PASS_B;
        legalD         = 1'b1;
      end
      LOAD: begin
        immD           = {{20{instrD[31]}}, instrD[31:20]};
        ctrlD.regWrite = 1'b1;
        ctrlD.memRead  = 1'b1;
        ctrlD.useImm   = 1'b1;
        legalD         = (funct3D == 3'b010);   // lw only
      end
      STORE: begin
        immD           = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
        ctrlD.memWrite = 1'b1;
        ctrlD.useImm   = 1'b1;
        legalD         = (funct3D == 3'b010);
      end
      BRANCH: begin
        immD = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
        ctrlD.branch   = 1'b1;
        ctrlD.branchNe = funct3D[0];
        legalD         = (funct3D[2:1] == 2'b00);   // beq, bne
      end
      JAL: begin
        immD = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};
        ctrlD.regWrite = 1'b1;
        ctrlD.jump     = 1'b1;
        legalD         = 1'b1;
      end
      default: legalD = 1'b0;
    endcase
    // illegal words pass through as no-ops
    if (!validD || !legalD) begin
      ctrlD.regWrite = 1'b0;
      ctrlD.memRead  = 1'b0;
      ctrlD.memWrite = 1'b0;
      ctrlD.branch   = 1'b0;
      ctrlD.jump     = 1'b0;
    end
    if (rdD == '0) begin
      ctrlD.regWrite = 1'b0;   // x0 writes dropped here
    end
  end

  ////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////

  logic [`XLEN-1:0] regFile [32];
  logic [`XLEN-1:0] rs1ValD;
  logic [`XLEN-1:0] rs2ValD;
  logic             wbWrite;

  assign wbWrite = retireW.valid && retireW.regWrite;

  always_ff @(posedge clk) begin
    if (wbWrite) begin
      regFile[retireW.rd] <= retireW.data;
    end
  end

  // writeback bypassed into the read, x0 reads as zero
  assign rs1ValD = (rs1D == '0) ? '0 :
                   (wbWrite && retireW.rd == rs1D) ? retireW.data : regFile[rs1D];
  assign rs2ValD = (rs2D == '0) ? '0 :
                   (wbWrite && retireW.rd == rs2D) ? retireW.data : regFile[rs2D];

  ////////////////////////////////////////////////////////////
  // decode to execute register
  ////////////////////////////////////////////////////////////

  ctrlT                   ctrlE;
  logic                   validE;
  logic [`XLEN-1:0]       pcE;
  logic [`XLEN-1:0]       immE;
  logic [`XLEN-1:0]       rs1ValE;
  logic [`XLEN-1:0]       rs2ValE;
  logic [`REG_ADDR_W-1:0] rs1E;
  logic [`REG_ADDR_W-1:0] rs2E;
  logic [`REG_ADDR_W-1:0] rdE;
  logic [`XLEN-1:0]       srcA;
  logic [`XLEN-1:0]       srcB;
  logic [`XLEN-1:0]       aluB;
  logic [`XLEN-1:0]       aluOut;
  logic [`XLEN-1:0]       linkE;
  logic                   operandsEq;

  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      validE <= 1'b0;
      ctrlE  <= '0;
    end else if (!stallE) begin
      validE <= validD;
      ctrlE  <= ctrlD;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallE) begin
      pcE     <= pcD;
      immE    <= immD;
      rs1E    <= rs1D;
      rs2E    <= rs2D;
      rdE     <= rdD;
      rs1ValE <= rs1ValD;
      rs2ValE <= rs2ValD;
    end else begin
      // held during a memory wait, writeback drains meanwhile
      rs1ValE <= srcA;
      rs2ValE <= srcB;
    end
  end

  ////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////

  // regWrite already implies a nonzero rd
  function automatic logic [`XLEN-1:0] fwdOperand(
    input logic [`REG_ADDR_W-1:0] rs,
    input logic [`XLEN-1:0]       regVal,
    input fwdT                    mem,
    input retireT                 wb
  );
    if (mem.valid && mem.regWrite && mem.rd == rs) begin
      return mem.data;
    end else if (wb.valid && wb.regWrite && wb.rd == rs) begin
      return wb.data;
    end
    return regVal;
  endfunction

  assign srcA = fwdOperand(rs1E, rs1ValE, fwdM, retireW);
  assign srcB = fwdOperand(rs2E, rs2ValE, fwdM, retireW);
  assign aluB = ctrlE.useImm ? immE : srcB;

  always_comb begin
    case (ctrlE.aluOp)
      ADD:     aluOut = srcA + aluB;
      SUB:     aluOut = srcA - aluB;
      AND:     aluOut = srcA & aluB;
      OR:      aluOut = srcA | aluB;
      XOR:     aluOut = srcA ^ aluB;
      SLT:     aluOut = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(aluB)};
      PASS_B:  aluOut = aluB;
      default: aluOut = '0;
    endcase
  end

  assign operandsEq = (srcA == srcB);
  assign linkE      = pcE + 'd4;

  assign redirect.taken  = validE &&
                           (ctrlE.jump || (ctrlE.branch && (operandsEq != ctrlE.branchNe)));
  assign redirect.target = pcE + immE;

  assign exMem.valid     = validE;
  assign exMem.pc        = pcE;
  assign exMem.rd        = rdE;
  assign exMem.regWrite  = ctrlE.regWrite;
  assign exMem.memRead   = ctrlE.memRead;
  assign exMem.memWrite  = ctrlE.memWrite;
  assign exMem.aluResult = ctrlE.jump ? linkE : aluOut;
  assign exMem.storeData = srcB;

  assign hazardInfo.rs1D     = rs1D;
  assign hazardInfo.rs2D     = rs2D;
  assign hazardInfo.rdE      = rdE;
  assign hazardInfo.memReadE = ctrlE.memRead;

endmodule

// File: hw/fetchUnit.sv
`include "rv_defines.svh"

module fetchUnit import rvPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                stallF,
  input  logic                stallD,
  input  logic                flushD,
  input  redirectT            redirect,
  output logic [`XLEN-1:0]    imemAdr,
  input  logic [`INSTR_W-1:0] imemData,
  output logic [`INSTR_W-1:0] instrD,
  output logic [`XLEN-1:0]    pcD,
  output logic                validD
);

  logic [`XLEN-1:0] pcF;
  logic [`XLEN-1:0] pcNextF;

  // not-taken prediction, execute overrides
  assign pcNextF = redirect.taken ? redirect.target : pcF + 'd4;
  assign imemAdr = pcF;   // read is asynchronous

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= `RESET_PC;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  ////////////////////////////////////////////////////////////
  // fetch to decode register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || flushD) begin
      validD <= 1'b0;   // wrong path or empty slot
    end else if (!stallD) begin
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      instrD <= imemData;
      pcD    <= pcF;
    end
  end

endmodule

// File: hw/hazardUnit.sv
`include "rv_defines.svh"

module hazardUnit import rvPkg::*; (
  input  hazardInfoT hazardInfo,
  input  redirectT   redirect,
  input  logic       memStall,
  output logic       stallF,
  output logic       stallD,
  output logic       stallE,
  output logic       stallM,
  output logic       flushD,
  output logic       flushE,
  output logic       flushW
);

  logic loadUse;

  // load result not ready for the next instruction
  assign loadUse = hazardInfo.memReadE && (hazardInfo.rdE != '0) &&
                   (hazardInfo.rdE == hazardInfo.rs1D || hazardInfo.rdE == hazardInfo.rs2D);

  always_comb begin
    {stallF, stallD, stallE, stallM} = 4'b0000;
    {flushD, flushE, flushW}         = 3'b000;
    if (memStall) begin
      {stallF, stallD, stallE, stallM} = 4'b1111;   // whole pipe holds
      flushW = 1'b1;
    end else if (redirect.taken) begin
      flushD = 1'b1;   // wrong-path fetch and decode
      flushE = 1'b1;
    end else if (loadUse) begin
      stallF = 1'b1;
      stallD = 1'b1;
      flushE = 1'b1;   // bubble into execute
    end
  end

endmodule

// File: hw/loadStoreUnit.sv
`include "rv_defines.svh"

module loadStoreUnit import rvPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             stallM,
  input  logic             flushW,
  input  exMemT            exMem,
  output dmemReqT          dmemReq,
  input  logic             dmemReady,
  input  logic [`XLEN-1:0] dmemRdata,
  output logic             memStall,
  output fwdT              fwdM,
  output retireT           retireW
);

  exMemT exM;         // memory stage
  logic  memAccess;

  always_ff @(posedge clk) begin
    if (rst) begin
      exM.valid <= 1'b0;
    end else if (!stallM) begin
      exM <= exMem;
    end
  end

  ////////////////////////////////////////////////////////////
  // data port
  ////////////////////////////////////////////////////////////

  assign memAccess = exM.valid && (exM.memRead || exM.memWrite);

  // fields come straight from the held stage register
  assign dmemReq.valid = memAccess;
  assign dmemReq.write = exM.memWrite;
  assign dmemReq.adr   = exM.aluResult;
  assign dmemReq.wdata = exM.storeData;

  assign memStall = memAccess && !dmemReady;   // waiting for ready

  assign fwdM.valid    = exM.valid;
  assign fwdM.rd       = exM.rd;
  assign fwdM.regWrite = exM.regWrite;
  assign fwdM.data     = exM.aluResult;

  // writeback register, empty while the port waits
  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      retireW.valid <= 1'b0;
    end else begin
      retireW.valid    <= exM.valid;
      retireW.pc       <= exM.pc;
      retireW.rd       <= exM.rd;
      retireW.regWrite <= exM.regWrite;
      retireW.data     <= exM.memRead ? dmemRdata : exM.aluResult;
    end
  end

endmodule

// File: hw/rvCore.sv
`include "rv_defines.svh"

module rvCore import rvPkg::*; (
  input  logic                clk,
  input  logic                rst,
  output logic [`XLEN-1:0]    imemAdr,
  input  logic [`INSTR_W-1:0] imemData,
  output dmemReqT             dmemReq,
  input  logic                dmemReady,
  input  logic [`XLEN-1:0]    dmemRdata,
  output retireT              retire
);

  logic                stallF;
  logic                stallD;
  logic                stallE;
  logic                stallM;
  logic                flushD;
  logic                flushE;
  logic                flushW;
  logic                memStall;
  logic [`INSTR_W-1:0] instrD;
  logic [`XLEN-1:0]    pcD;
  logic                validD;
  redirectT            redirect;
  hazardInfoT          hazardInfo;
  exMemT               exMem;
  fwdT                 fwdM;

  // pc and fetch/decode register
  fetchUnit fetch (.clk, .rst, .stallF, .stallD, .flushD, .redirect,
    .imemAdr, .imemData, .instrD, .pcD, .validD);

  // decode, register file, alu and branch resolution
  execUnit exec (.clk, .rst, .stallE, .flushE,
    .instrD, .pcD, .validD,
    .hazardInfo, .redirect, .exMem,
    .fwdM, .retireW(retire));

  // memory and writeback stages
  loadStoreUnit lsu (.clk, .rst, .stallM, .flushW,
    .exMem, .dmemReq, .dmemReady, .dmemRdata,
    .memStall, .fwdM, .retireW(retire));

  ////////////////////////////////////////////////////////////
  // stall and flush control
  ////////////////////////////////////////////////////////////

  hazardUnit hzu (.hazardInfo, .redirect, .memStall,
    .stallF, .stallD, .stallE, .stallM,
    .flushD, .flushE, .flushW);

endmodule

// File: hw/rvPkg.sv
`include "rv_defines.svh"

package rvPkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcodeE;

  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    AND    = 3'd2,
    OR     = 3'd3,
    XOR    = 3'd4,
    SLT    = 3'd5,
    PASS_B = 3'd6   // lui, immediate straight through
  } aluOpE;

  ////////////////////////////////////////////////////////////
  // records between units
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  branchNe;   // bne when set, beq otherwise
    logic  jump;
    logic  useImm;
    aluOpE aluOp;
  } ctrlT;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rs1D;
    logic [`REG_ADDR_W-1:0] rs2D;
    logic [`REG_ADDR_W-1:0] rdE;
    logic                   memReadE;
  } hazardInfoT;

  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } redirectT;

  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   regWrite;
    logic                   memRead;
    logic                   memWrite;
    logic [`XLEN-1:0]       aluResult;   // address for loads and stores, link for jal
    logic [`XLEN-1:0]       storeData;
  } exMemT;

  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   regWrite;
    logic [`XLEN-1:0]       data;
  } fwdT;

  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   regWrite;
    logic [`XLEN-1:0]       data;
  } retireT;

  typedef struct packed {
    logic             valid;
    logic             write;
    logic [`XLEN-1:0] adr;
    logic [`XLEN-1:0] wdata;
  } dmemReqT;

endpackage

// File: hw/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

////////////////////////////////////////////////////////////
// core widths
////////////////////////////////////////////////////////////

// data and address width
`define XLEN 32

// register index, 32 integer registers
`define REG_ADDR_W 5

// base instructions only, no compressed
`define INSTR_W 32

////////////////////////////////////////////////////////////
// reset
////////////////////////////////////////////////////////////

`define RESET_PC 32'h0000_0000   // first fetch address

`endif

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f rvCore.f \
  --top-module rvCoreTb -o rvCoreSim &&
./obj_dir/rvCoreSim | tee /dev/stderr | grep -q "^TEST OK$" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

// File: rvCore.f
+incdir+hw
hw/rvPkg.sv
hw/fetchUnit.sv
hw/execUnit.sv
hw/loadStoreUnit.sv
hw/hazardUnit.sv
hw/rvCore.sv
dv/rvCore_props.sv
dv/rvCoreTb.sv
